// File: all.f
common/cdc_pkg.sv
common/wb_regs_pkg.sv
async_fifo/async_fifo.sv
hw/sample_packer.sv
hw/wb_capture_regs.sv
hw/capture_top.sv
bench/capture_props.sv
bench/capture_tb.sv

// File: Bender.yml
package:
  name: capture

sources:
  # Packages
  - common/cdc_pkg.sv
  - common/wb_regs_pkg.sv
  # RTL
  - async_fifo/async_fifo.sv
  - hw/sample_packer.sv
  - hw/wb_capture_regs.sv
  - hw/capture_top.sv
  # Testbench
  - target: test
    files:
      - bench/capture_props.sv
      - bench/capture_tb.sv

// File: bench/capture_tb.sv
`timescale 1ns/1ps
`default_nettype none

module capture_tb;

    localparam realtime RD_HALF = 4.0;
    localparam realtime WR_HALF = 5.5;
    localparam int ACK_TIMEOUT = 50;
    localparam int POLL_LIMIT = 20;
    // Command crossing takes 2 to 3 edges plus pop and apply
    localparam int CMD_SETTLE = 10;
    localparam int TBL_LEN = 16;

    logic        wr_clk;
    logic        wr_rst_n;
    logic        sample_valid;
    logic [1:0]  sample_channel;
    logic [15:0] sample_value;
    logic        rd_clk;
    logic        rd_rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [3:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [3:0]  wb_sel;
    logic [31:0] wb_dat_r;
    logic        wb_ack;

    int          pass_count;
    int          fail_count;
    int          test_fail_start;
    logic [31:0] lcg_state;
    logic [7:0]  exp_seq;
    logic [15:0] sent_values [$];

    // --------------------
    // Stimulus table with the first half under mask 0xF and the second under 0x5
    // --------------------
    logic [1:0] tbl_chan [TBL_LEN] = '{2'd0, 2'd1, 2'd2, 2'd3, 2'd3, 2'd2, 2'd1, 2'd0,
                                       2'd0, 2'd1, 2'd2, 2'd3, 2'd1, 2'd2, 2'd3, 2'd0};
    logic tbl_enabled [TBL_LEN] = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1,
                                    1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1};
    logic tbl_expect [TBL_LEN] = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1,
                                   1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1};
    logic [15:0] tbl_value [TBL_LEN];

    capture_top i_capture_top (
        .wr_clk         (wr_clk),
        .wr_rst_n       (wr_rst_n),
        .sample_valid   (sample_valid),
        .sample_channel (sample_channel),
        .sample_value   (sample_value),
        .rd_clk         (rd_clk),
        .rd_rst_n       (rd_rst_n),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_dat_w       (wb_dat_w),
        .wb_sel         (wb_sel),
        .wb_dat_r       (wb_dat_r),
        .wb_ack         (wb_ack)
    );

    bind async_fifo capture_props u_fifo_props (
        .clk_a (wr_clk), .rst_a_n (wr_rst_n), .push (wr_en), .full (full),
        .clk_b (rd_clk), .rst_b_n (rd_rst_n), .pop (rd_en), .empty (empty),
        .cyc (1'b0), .stb (1'b0), .ack (1'b0)
    );

    bind wb_capture_regs capture_props u_bus_props (
        .clk_a (rd_clk), .rst_a_n (rd_rst_n), .push (cmd_wr_en), .full (cmd_full),
        .clk_b (rd_clk), .rst_b_n (rd_rst_n), .pop (smp_rd_en), .empty (smp_empty),
        .cyc (wb_cyc), .stb (wb_stb), .ack (wb_ack)
    );

    initial begin
        rd_clk = 1'b0;
        forever #RD_HALF rd_clk = ~rd_clk;
    end

    initial begin
        wr_clk = 1'b0;
        forever #WR_HALF wr_clk = ~wr_clk;
    end

    function automatic logic [15:0] lcg_next_value();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    // DATA word from the top is valid, gap, unused, channel, sequence and value
    function automatic logic [31:0] expected_data_word(input logic gap, input logic [1:0] ch,
                                                       input logic [7:0] seq,
                                                       input logic [15:0] value);
        return {1'b1, gap, 4'b0000, ch, seq, value};
    endfunction

    task automatic compare_word(input logic [31:0] got, input logic [31:0] exp,
                                input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s: got %h, expected %h", $time, what, got, exp);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    // --------------------
    // Bus access
    // --------------------
    task automatic bus_transfer(input logic we, input logic [3:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata);
        int   waited;
        logic got_ack;
        @(posedge rd_clk);
        #1;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = addr;
        wb_dat_w = wdata;
        wb_sel = 4'hF;
        waited = 0;
        got_ack = 1'b0;
        rdata = '0;
        while (!got_ack && waited < ACK_TIMEOUT) begin
            @(posedge rd_clk);
            #1;
            waited++;
            if (wb_ack) begin
                got_ack = 1'b1;
                rdata = wb_dat_r;
            end
        end
        if (!got_ack) begin
            $display("Timeout: the bus slave gave no ack for address %h", addr);
            fail_count++;
        end else begin
            // Transfer completes on the next edge
            @(posedge rd_clk);
            #1;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    task automatic wb_read(input logic [3:0] addr, output logic [31:0] data);
        bus_transfer(1'b0, addr, 32'h0, data);
    endtask

    task automatic wb_write(input logic [3:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        bus_transfer(1'b1, addr, data, unused);
    endtask

    task automatic write_ctrl(input logic [3:0] mask, input logic clear);
        logic [31:0] status;
        wb_write(wb_regs_pkg::ADDR_CTRL, {23'd0, clear, 4'd0, mask});
        // STATUS shows the mask as last written
        wb_read(wb_regs_pkg::ADDR_STATUS, status);
        compare_word({28'd0, status[7:4]}, {28'd0, mask}, "STATUS mask after CTRL write");
        repeat (CMD_SETTLE) @(posedge wr_clk);
    endtask

    // Polls DATA until a word with valid set comes back
    task automatic read_sample(output logic [31:0] word);
        int tries;
        tries = 0;
        word = '0;
        while (!word[31] && tries < POLL_LIMIT) begin
            wb_read(wb_regs_pkg::ADDR_DATA, word);
            tries++;
        end
        if (!word[31]) begin
            $display("Timeout: no sample became readable after %0d reads", POLL_LIMIT);
            fail_count++;
        end
    endtask

    task automatic wait_status_not_empty();
        logic [31:0] status;
        int          tries;
        tries = 0;
        status = 32'h1;
        while (status[0] && tries < POLL_LIMIT) begin
            wb_read(wb_regs_pkg::ADDR_STATUS, status);
            tries++;
        end
        if (status[0]) begin
            $display("Timeout: STATUS still shows the sample FIFO empty");
            fail_count++;
        end
    endtask

    task automatic send_sample(input logic [1:0] ch, input logic [15:0] value);
        @(posedge wr_clk);
        #1;
        sample_valid = 1'b1;
        sample_channel = ch;
        sample_value = value;
        @(posedge wr_clk);
        #1;
        sample_valid = 1'b0;
    endtask

    task automatic run_table(input int first, input int last);
        logic [31:0] got;
        for (int i = first; i <= last; i++) begin
            send_sample(tbl_chan[i], tbl_value[i]);
        end
        for (int i = first; i <= last; i++) begin
            if (tbl_expect[i]) begin
                read_sample(got);
                compare_word(got, expected_data_word(1'b0, tbl_chan[i], exp_seq, tbl_value[i]),
                             $sformatf("table entry %0d", i));
            end
            // Only stored samples advance the sequence
            if (tbl_enabled[i]) begin
                exp_seq++;
            end
        end
        wb_read(wb_regs_pkg::ADDR_DATA, got);
        compare_word(got, 32'h0, "no further samples after table");
    endtask

    task automatic finish_test(input int num, input string name);
        if (fail_count == test_fail_start) begin
            $display("Test %0d %s: passed", num, name);
        end else begin
            $display("Test %0d %s: FAILED with %0d errors", num, name,
                     fail_count - test_fail_start);
        end
        test_fail_start = fail_count;
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        logic [31:0] got;
        wr_rst_n = 1'b0;
        rd_rst_n = 1'b0;
        sample_valid = 1'b0;
        sample_channel = '0;
        sample_value = '0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        wb_sel = '0;
        pass_count = 0;
        fail_count = 0;
        test_fail_start = 0;
        exp_seq = 8'd0;
        lcg_state = 32'h9e56;
        for (int i = 0; i < TBL_LEN; i++) begin
            tbl_value[i] = lcg_next_value();
        end

        repeat (5) @(posedge rd_clk);
        #1;
        rd_rst_n = 1'b1;
        @(posedge wr_clk);
        #1;
        wr_rst_n = 1'b1;

        // Sample FIFO empty, command FIFO not full, mask 0
        wb_read(wb_regs_pkg::ADDR_STATUS, got);
        compare_word(got, 32'h0000_0001, "STATUS after reset");
        wb_read(wb_regs_pkg::ADDR_DATA, got);
        compare_word(got, 32'h0, "DATA read while empty");
        finish_test(1, "reset state");

        write_ctrl(4'hF, 1'b0);
        run_table(0, 7);
        finish_test(2, "all channels enabled");

        write_ctrl(4'h5, 1'b0);
        run_table(8, 15);
        finish_test(3, "channel mask");

        // Overflow with reads paused
        write_ctrl(4'hF, 1'b0);
        for (int i = 0; i < cdc_pkg::FIFO_DEPTH + 3; i++) begin
            sent_values.push_back(lcg_next_value());
            send_sample(i[1:0], sent_values[i]);
        end
        wait_status_not_empty();
        for (int i = 0; i < cdc_pkg::FIFO_DEPTH; i++) begin
            read_sample(got);
            compare_word(got, expected_data_word(1'b0, i[1:0], exp_seq, sent_values[i]),
                         $sformatf("drained sample %0d", i));
            exp_seq++;
        end
        wb_read(wb_regs_pkg::ADDR_DATA, got);
        compare_word(got, 32'h0, "FIFO empty after drain");
        sent_values.push_back(lcg_next_value());
        send_sample(2'd2, sent_values[$]);
        read_sample(got);
        compare_word(got, expected_data_word(1'b1, 2'd2, exp_seq, sent_values[$]),
                     "first sample after overflow");
        finish_test(4, "overflow gap");

        write_ctrl(4'hF, 1'b1);
        exp_seq = 8'd0;
        sent_values.push_back(lcg_next_value());
        send_sample(2'd1, sent_values[$]);
        read_sample(got);
        compare_word(got, expected_data_word(1'b0, 2'd1, exp_seq, sent_values[$]),
                     "sample after sequence clear");
        finish_test(5, "sequence clear");

        $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/capture_props.sv
`timescale 1ns/1ps
`default_nettype none

module capture_props (
    input logic clk_a,
    input logic rst_a_n,
    input logic push,
    input logic full,
    input logic clk_b,
    input logic rst_b_n,
    input logic pop,
    input logic empty,
    input logic cyc,
    input logic stb,
    input logic ack
);

    // --------------------
    // Wishbone side
    // --------------------
    ack_needs_request: assert property (
        @(posedge clk_b) disable iff (!rst_b_n) ack |-> (cyc && stb)
    ) else $error("ack raised without cyc and stb");

    ack_single_cycle: assert property (
        @(posedge clk_b) disable iff (!rst_b_n) ack |=> !ack
    ) else $error("ack held for more than one cycle");

    // --------------------
    // FIFO handshakes
    // --------------------
    no_push_when_full: assert property (
        @(posedge clk_a) disable iff (!rst_a_n) push |-> !full
    ) else $error("FIFO write while full");

    no_pop_when_empty: assert property (
        @(posedge clk_b) disable iff (!rst_b_n) pop |-> !empty
    ) else $error("FIFO read while empty");

endmodule

`default_nettype wire

// File: hw/capture_top.sv
`timescale 1ns/1ps
`default_nettype none

module capture_top (
    // Write domain
    input  logic                              wr_clk,
    input  logic                              wr_rst_n,
    input  logic                              sample_valid,
    input  logic [cdc_pkg::CHAN_W-1:0]        sample_channel,
    input  logic [cdc_pkg::VALUE_W-1:0]       sample_value,

    // Read domain
    input  logic                              rd_clk,
    input  logic                              rd_rst_n,
    input  logic                              wb_cyc,
    input  logic                              wb_stb,
    input  logic                              wb_we,
    input  logic [wb_regs_pkg::WB_ADDR_W-1:0] wb_adr,
    input  logic [wb_regs_pkg::WB_DATA_W-1:0] wb_dat_w,
    input  logic [wb_regs_pkg::WB_SEL_W-1:0]  wb_sel,
    output logic [wb_regs_pkg::WB_DATA_W-1:0] wb_dat_r,
    output logic                              wb_ack
);

    logic             smp_wr_en;
    cdc_pkg::sample_t smp_wr_data;
    logic             smp_full;
    logic             smp_rd_en;
    cdc_pkg::sample_t smp_rd_data;
    logic             smp_empty;

    logic             cmd_wr_en;
    cdc_pkg::cmd_t    cmd_wr_data;
    logic             cmd_full;
    logic             cmd_rd_en;
    cdc_pkg::cmd_t    cmd_rd_data;
    logic             cmd_empty;

    sample_packer u_packer (
        .wr_clk         (wr_clk),
        .wr_rst_n       (wr_rst_n),
        .sample_valid   (sample_valid),
        .sample_channel (sample_channel),
        .sample_value   (sample_value),
        .fifo_full      (smp_full),
        .fifo_wr_en     (smp_wr_en),
        .fifo_wr_data   (smp_wr_data),
        .cmd_empty      (cmd_empty),
        .cmd_data       (cmd_rd_data),
        .cmd_rd_en      (cmd_rd_en)
    );

    // --------------------
    // Samples, wr_clk to rd_clk
    // --------------------
    async_fifo #(
        .payload_t (cdc_pkg::sample_t),
        .DEPTH     (cdc_pkg::FIFO_DEPTH)
    ) u_sample_fifo (
        .wr_clk   (wr_clk),
        .wr_rst_n (wr_rst_n),
        .wr_en    (smp_wr_en),
        .wr_data  (smp_wr_data),
        .rd_clk   (rd_clk),
        .rd_rst_n (rd_rst_n),
        .rd_en    (smp_rd_en),
        .rd_data  (smp_rd_data),
        .full     (smp_full),
        .empty    (smp_empty)
    );

    // --------------------
    // Commands, rd_clk to wr_clk
    // --------------------
    async_fifo #(
        .payload_t (cdc_pkg::cmd_t),
        .DEPTH     (cdc_pkg::CMD_DEPTH)
    ) u_cmd_fifo (
        .wr_clk   (rd_clk),
        .wr_rst_n (rd_rst_n),
        .wr_en    (cmd_wr_en),
        .wr_data  (cmd_wr_data),
        .rd_clk   (wr_clk),
        .rd_rst_n (wr_rst_n),
        .rd_en    (cmd_rd_en),
        .rd_data  (cmd_rd_data),
        .full     (cmd_full),
        .empty    (cmd_empty)
    );

    wb_capture_regs u_regs (
        .rd_clk    (rd_clk),
        .rd_rst_n  (rd_rst_n),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_sel    (wb_sel),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .smp_empty (smp_empty),
        .smp_data  (smp_rd_data),
        .smp_rd_en (smp_rd_en),
        .cmd_full  (cmd_full),
        .cmd_wr_en (cmd_wr_en),
        .cmd_data  (cmd_wr_data)
    );

endmodule

`default_nettype wire

// File: hw/wb_capture_regs.sv
`timescale 1ns/1ps
`default_nettype none

module wb_capture_regs (
    input  logic                              rd_clk,
    input  logic                              rd_rst_n,

    input  logic                              wb_cyc,
    input  logic                              wb_stb,
    input  logic                              wb_we,
    input  logic [wb_regs_pkg::WB_ADDR_W-1:0] wb_adr,
    input  logic [wb_regs_pkg::WB_DATA_W-1:0] wb_dat_w,
    input  logic [wb_regs_pkg::WB_SEL_W-1:0]  wb_sel,
    output logic [wb_regs_pkg::WB_DATA_W-1:0] wb_dat_r,
    output logic                              wb_ack,

    input  logic                              smp_empty,
    input  cdc_pkg::sample_t                  smp_data,
    output logic                              smp_rd_en,

    input  logic                              cmd_full,
    output logic                              cmd_wr_en,
    output cdc_pkg::cmd_t                     cmd_data
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_POP_WAIT,
        ST_RESPOND
    } state_t;

    state_t                            state;
    logic [cdc_pkg::NUM_CHANNELS-1:0]  mask_shadow;
    logic                              req;
    logic                              sel_data;
    logic                              sel_status;
    logic                              sel_ctrl;
    logic                              ctrl_stall;
    logic [wb_regs_pkg::WB_DATA_W-1:0] data_word;
    logic [wb_regs_pkg::WB_DATA_W-1:0] status_word;

    // --------------------
    // Decode
    // --------------------
    // Only idle takes a new transfer, so a held stb after ack is not reused
    assign req = wb_cyc && wb_stb && (state == ST_IDLE);

    assign sel_data = (wb_adr == wb_regs_pkg::ADDR_DATA);
    assign sel_status = (wb_adr == wb_regs_pkg::ADDR_STATUS);
    assign sel_ctrl = (wb_adr == wb_regs_pkg::ADDR_CTRL);

    // Host waits while the command FIFO has no room
    assign ctrl_stall = wb_we && sel_ctrl && cmd_full;

    assign smp_rd_en = req && !wb_we && sel_data && !smp_empty;
    assign cmd_wr_en = req && wb_we && sel_ctrl && !cmd_full;

    // Mask byte not selected keeps the current mask
    always_comb begin
        cmd_data.enable = wb_sel[wb_regs_pkg::CTRL_MASK_LSB / 8]
            ? wb_dat_w[wb_regs_pkg::CTRL_MASK_LSB +: cdc_pkg::NUM_CHANNELS]
            : mask_shadow;
        cmd_data.clear_seq = wb_sel[wb_regs_pkg::CTRL_CLEAR_BIT / 8]
            && wb_dat_w[wb_regs_pkg::CTRL_CLEAR_BIT];
    end

    // --------------------
    // Read words
    // --------------------
    always_comb begin
        data_word = '0;
        data_word[wb_regs_pkg::DATA_VALID_BIT] = 1'b1;
        data_word[wb_regs_pkg::DATA_GAP_BIT] = smp_data.gap;
        data_word[wb_regs_pkg::DATA_CHAN_LSB +: cdc_pkg::CHAN_W] = smp_data.channel;
        data_word[wb_regs_pkg::DATA_SEQ_LSB +: cdc_pkg::SEQ_W] = smp_data.seq;
        data_word[wb_regs_pkg::DATA_VALUE_LSB +: cdc_pkg::VALUE_W] = smp_data.value;
    end

    always_comb begin
        status_word = '0;
        status_word[wb_regs_pkg::STAT_SMP_EMPTY_BIT] = smp_empty;
        status_word[wb_regs_pkg::STAT_CMD_FULL_BIT] = cmd_full;
        status_word[wb_regs_pkg::STAT_MASK_LSB +: cdc_pkg::NUM_CHANNELS] = mask_shadow;
    end

    // --------------------
    // FSM
    // --------------------
    always_ff @(posedge rd_clk or negedge rd_rst_n) begin
        if (!rd_rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (smp_rd_en) begin
                        state <= ST_POP_WAIT;
                    end else if (req && !ctrl_stall) begin
                        state <= ST_RESPOND;
                    end
                end
                ST_POP_WAIT: state <= ST_RESPOND;
                default:     state <= ST_IDLE;
            endcase
        end
    end

    assign wb_ack = (state == ST_RESPOND);

    // Popped sample is on smp_data during pop wait
    always_ff @(posedge rd_clk) begin
        if (state == ST_POP_WAIT) begin
            wb_dat_r <= data_word;
        end else if (req) begin
            wb_dat_r <= (!wb_we && sel_status) ? status_word : '0;
        end
    end

    always_ff @(posedge rd_clk or negedge rd_rst_n) begin
        if (!rd_rst_n) begin
            mask_shadow <= '0;
        end else if (cmd_wr_en) begin
            mask_shadow <= cmd_data.enable;
        end
    end

endmodule

`default_nettype wire

// File: hw/sample_packer.sv
`timescale 1ns/1ps
`default_nettype none

module sample_packer (
    input  logic                           wr_clk,
    input  logic                           wr_rst_n,

    input  logic                           sample_valid,
    input  logic [cdc_pkg::CHAN_W-1:0]     sample_channel,
    input  logic [cdc_pkg::VALUE_W-1:0]    sample_value,

    input  logic                           fifo_full,
    output logic                           fifo_wr_en,
    output cdc_pkg::sample_t               fifo_wr_data,

    input  logic                           cmd_empty,
    input  cdc_pkg::cmd_t                  cmd_data,
    output logic                           cmd_rd_en
);

    logic [cdc_pkg::NUM_CHANNELS-1:0] enable_mask;
    logic [cdc_pkg::SEQ_W-1:0]        seq;
    logic                             gap_pending;
    logic                             cmd_loaded;
    logic                             chan_enabled;

    // --------------------
    // Sample path
    // --------------------
    assign chan_enabled = sample_valid && enable_mask[sample_channel];

    // No back-pressure, a sample is stored or lost in its own cycle
    assign fifo_wr_en = chan_enabled && !fifo_full;

    always_comb begin
        fifo_wr_data.gap     = gap_pending;
        fifo_wr_data.channel = sample_channel;
        fifo_wr_data.seq     = seq;
        fifo_wr_data.value   = sample_value;
    end

    always_ff @(posedge wr_clk or negedge wr_rst_n) begin
        if (!wr_rst_n) begin
            gap_pending <= 1'b0;
        end else if (fifo_wr_en) begin
            gap_pending <= 1'b0;
        end else if (chan_enabled && fifo_full) begin
            // Lost sample, flag it on the next stored one
            gap_pending <= 1'b1;
        end
    end

    // Clear from a command beats a same-cycle increment
    always_ff @(posedge wr_clk or negedge wr_rst_n) begin
        if (!wr_rst_n) begin
            seq <= '0;
        end else if (cmd_loaded && cmd_data.clear_seq) begin
            seq <= '0;
        end else if (fifo_wr_en) begin
            seq <= seq + 1'b1;
        end
    end

    // --------------------
    // Command path
    // --------------------
    // Pop as soon as anything is waiting
    assign cmd_rd_en = !cmd_empty;

    // Popped data shows up one cycle later
    always_ff @(posedge wr_clk or negedge wr_rst_n) begin
        if (!wr_rst_n) begin
            cmd_loaded <= 1'b0;
        end else begin
            cmd_loaded <= cmd_rd_en;
        end
    end

    always_ff @(posedge wr_clk or negedge wr_rst_n) begin
        if (!wr_rst_n) begin
            enable_mask <= '0;
        end else if (cmd_loaded) begin
            enable_mask <= cmd_data.enable;
        end
    end

endmodule

`default_nettype wire

// File: async_fifo/async_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module async_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 16
) (
    input  logic     wr_clk,
    input  logic     wr_rst_n,
    input  logic     wr_en,
    input  payload_t wr_data,

    input  logic     rd_clk,
    input  logic     rd_rst_n,
    input  logic     rd_en,
    output payload_t rd_data,

    output logic     full,
    output logic     empty
);

    localparam int ADDR_W = $clog2(DEPTH);
    localparam int PTR_W = ADDR_W + 1;

    // Selects the two top bits of a Gray pointer
    localparam logic [PTR_W-1:0] TOP2_MASK = PTR_W'(3) << (ADDR_W - 1);

    payload_t mem [DEPTH];

    // Write domain
    logic             wr_fire;
    logic [PTR_W-1:0] wr_bin;
    logic [PTR_W-1:0] wr_bin_next;
    logic [PTR_W-1:0] wr_gray;
    logic [PTR_W-1:0] rd_gray_s1;
    logic [PTR_W-1:0] rd_gray_s2;

    // Read domain
    logic             rd_fire;
    logic [PTR_W-1:0] rd_bin;
    logic [PTR_W-1:0] rd_bin_next;
    logic [PTR_W-1:0] rd_gray;
    logic [PTR_W-1:0] wr_gray_s1;
    logic [PTR_W-1:0] wr_gray_s2;

    // --------------------
    // Write side
    // --------------------
    assign wr_fire = wr_en && !full;
    assign wr_bin_next = wr_bin + PTR_W'(1);

    always_ff @(posedge wr_clk) begin
        if (wr_fire) begin
            mem[wr_bin[ADDR_W-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge wr_clk or negedge wr_rst_n) begin
        if (!wr_rst_n) begin
            wr_bin  <= '0;
            wr_gray <= '0;
        end else if (wr_fire) begin
            wr_bin  <= wr_bin_next;
            wr_gray <= wr_bin_next ^ (wr_bin_next >> 1);
        end
    end

    // Read pointer into the write domain
    always_ff @(posedge wr_clk or negedge wr_rst_n) begin
        if (!wr_rst_n) begin
            rd_gray_s1 <= '0;
            rd_gray_s2 <= '0;
        end else begin
            rd_gray_s1 <= rd_gray;
            rd_gray_s2 <= rd_gray_s1;
        end
    end

    // --------------------
    // Read side
    // --------------------
    assign rd_fire = rd_en && !empty;
    assign rd_bin_next = rd_bin + PTR_W'(1);

    // Read data holds until the next pop
    always_ff @(posedge rd_clk) begin
        if (rd_fire) begin
            rd_data <= mem[rd_bin[ADDR_W-1:0]];
        end
    end

    always_ff @(posedge rd_clk or negedge rd_rst_n) begin
        if (!rd_rst_n) begin
            rd_bin  <= '0;
            rd_gray <= '0;
        end else if (rd_fire) begin
            rd_bin  <= rd_bin_next;
            rd_gray <= rd_bin_next ^ (rd_bin_next >> 1);
        end
    end

    // Write pointer into the read domain
    always_ff @(posedge rd_clk or negedge rd_rst_n) begin
        if (!rd_rst_n) begin
            wr_gray_s1 <= '0;
            wr_gray_s2 <= '0;
        end else begin
            wr_gray_s1 <= wr_gray;
            wr_gray_s2 <= wr_gray_s1;
        end
    end

    // --------------------
    // Flags
    // --------------------
    // Synchronized pointers lag, so both flags err on the safe side
    assign empty = (rd_gray == wr_gray_s2);

    // wr_gray names the slot of the next write; full when it laps the reader
    assign full = (wr_gray == (rd_gray_s2 ^ TOP2_MASK));

endmodule

`default_nettype wire

// File: common/wb_regs_pkg.sv
`default_nettype none

package wb_regs_pkg;

    // --------------------
    // Bus widths
    // --------------------
    localparam int WB_ADDR_W = 4;
    localparam int WB_DATA_W = 32;
    localparam int WB_SEL_W = WB_DATA_W / 8;

    // Register byte addresses
    localparam logic [WB_ADDR_W-1:0] ADDR_DATA = 4'h0;
    localparam logic [WB_ADDR_W-1:0] ADDR_STATUS = 4'h4;
    localparam logic [WB_ADDR_W-1:0] ADDR_CTRL = 4'h8;

    // --------------------
    // Word fields
    // --------------------
    localparam int DATA_VALID_BIT = 31;
    localparam int DATA_GAP_BIT = 30;
    localparam int DATA_CHAN_LSB = 24;
    localparam int DATA_SEQ_LSB = 16;
    localparam int DATA_VALUE_LSB = 0;

    localparam int STAT_SMP_EMPTY_BIT = 0;
    localparam int STAT_CMD_FULL_BIT = 1;
    localparam int STAT_MASK_LSB = 4;

    localparam int CTRL_MASK_LSB = 0;
    localparam int CTRL_CLEAR_BIT = 8;

endpackage

`default_nettype wire

// File: common/cdc_pkg.sv
`default_nettype none

package cdc_pkg;

    // --------------------
    // Sizes
    // --------------------

    // Sample FIFO entries, power of two
    localparam int FIFO_DEPTH = 16;
    // Command FIFO entries, power of two
    localparam int CMD_DEPTH = 4;

    localparam int NUM_CHANNELS = 4;
    localparam int CHAN_W = $clog2(NUM_CHANNELS);
    localparam int SEQ_W = 8;
    localparam int VALUE_W = 16;

    // --------------------
    // Payloads
    // --------------------

    // Stored sample, write domain to read domain
    typedef struct packed {
        logic               gap;
        logic [CHAN_W-1:0]  channel;
        logic [SEQ_W-1:0]   seq;
        logic [VALUE_W-1:0] value;
    } sample_t;

    // Control word, read domain to write domain
    typedef struct packed {
        logic [NUM_CHANNELS-1:0] enable;
        logic                    clear_seq;
    } cmd_t;

endpackage

`default_nettype wire
